//--- hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // byte offset inside one line
    localparam int offset_width = 4;

    // 32-bit words per line
    localparam int line_words = 4;

    // pipe and bus word
    typedef logic [31:0] word_t;

    // one full cache line, word 0 in the low bits
    typedef logic [127:0] line_t;

    // word position inside a line
    typedef logic [1:0] word_sel_t;

    // read type codes on the memory bus
    localparam logic [2:0] rd_type_word = 3'b010;
    localparam logic [2:0] rd_type_line = 3'b100;

    // main controller states
    typedef enum logic [1:0] {
        idle,
        lookup,
        refill
    } cache_state_t;

    // tag bits left over from a 32-bit address
    function automatic int tag_width_of(input int index_width);
        return 32 - index_width - offset_width;
    endfunction

endpackage

`default_nettype wire

//--- hdl/icache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tag_store #(
    parameter int index_width = 8,
    localparam int tag_width = icache_pkg::tag_width_of(index_width)
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   preload,
    input  logic [index_width-1:0] preload_index,
    input  logic [tag_width-1:0]   lookup_tag,
    input  logic [index_width-1:0] lookup_index,
    input  logic                   fill,
    input  logic                   fill_way,
    output logic                   hit,
    output logic                   hit_way
);

    localparam int ways = 2;
    localparam int sets = 1 << index_width;

    // tag arrays, one per way
    logic [tag_width-1:0] tag_mem [ways][sets];

    // valid bits, one vector per way
    logic [sets-1:0] valid_mem [ways];

    // tags of the accepted set, read one cycle ahead of the compare
    logic [tag_width-1:0] pre_tag [ways];

    logic [ways-1:0] way_hit;

    // refill write and preload read share the clock edge
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[fill_way][lookup_index] <= lookup_tag;
        end
        if (preload) begin
            for (int w = 0; w < ways; w++) begin
                pre_tag[w] <= tag_mem[w][preload_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < ways; w++) begin
                valid_mem[w] <= '0;
            end
        end else if (fill) begin
            valid_mem[fill_way][lookup_index] <= 1'b1;
        end
    end

    // valid is looked up live, the tag comes from the preload register
    generate
        for (genvar w = 0; w < ways; w++) begin : g_cmp
            assign way_hit[w] = valid_mem[w][lookup_index] && (pre_tag[w] == lookup_tag);
        end
    endgenerate

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // refill only happens on a miss, so one tag never sits in both ways
    assert property (@(posedge clk) disable iff (!resetn)
        !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

//--- hdl/icache_data_store.sv
`timescale 1ns/100ps
`default_nettype none

module icache_data_store #(
    parameter int index_width = 8
) (
    input  logic                   clk,
    input  logic                   preload,
    input  logic [index_width-1:0] preload_index,
    input  logic                   hit_way,
    input  logic                   fill,
    input  logic                   fill_way,
    input  logic [index_width-1:0] fill_index,
    input  icache_pkg::line_t      fill_line,
    output icache_pkg::line_t      hit_line
);

    localparam int ways = 2;
    localparam int sets = 1 << index_width;

    // line arrays, one per way
    icache_pkg::line_t line_mem [ways][sets];

    // both candidate lines of the accepted set
    icache_pkg::line_t pre_line [ways];

    always_ff @(posedge clk) begin
        if (fill) begin
            line_mem[fill_way][fill_index] <= fill_line;
        end
    end

    // read both ways in the accept cycle, pick one after the tag compare
    always_ff @(posedge clk) begin
        if (preload) begin
            for (int w = 0; w < ways; w++) begin
                pre_line[w] <= line_mem[w][preload_index];
            end
        end
    end

    assign hit_line = pre_line[hit_way];

endmodule

`default_nettype wire

//--- hdl/icache_line_fill.sv
`timescale 1ns/100ps
`default_nettype none

module icache_line_fill (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  icache_pkg::word_t ret_data,
    output icache_pkg::line_t line,
    output icache_pkg::line_t line_next
);

    localparam int word_bits = $bits(icache_pkg::word_t);

    icache_pkg::line_t     fill_buf;
    icache_pkg::word_sel_t beat;
    logic                  active;
    logic                  take;

    // beats count only inside an issued burst
    assign take = ret_valid && active;

    // buffer with the current beat already merged in
    always_comb begin
        line_next = fill_buf;
        if (take) begin
            line_next[word_bits*beat +: word_bits] = ret_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
            beat   <= '0;
        end else if (start) begin
            active <= 1'b1;
            beat   <= '0;
        end else if (take) begin
            beat <= beat + 1'b1;
            if (ret_last) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            fill_buf <= '0;
        end else if (take) begin
            fill_buf <= line_next;
        end
    end

    assign line = fill_buf;

    // memory answers only what was asked for
    assert property (@(posedge clk) disable iff (!resetn) ret_valid |-> active);

    // a burst ends after one word or after a full line
    assert property (@(posedge clk) disable iff (!resetn)
        take && ret_last |-> beat == 0 || beat == icache_pkg::line_words - 1);

endmodule

`default_nettype wire

//--- hdl/icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl #(
    parameter int index_width = 8,
    localparam int tag_width = icache_pkg::tag_width_of(index_width)
) (
    input  logic                                clk,
    input  logic                                resetn,
    // pipe side
    input  logic                                valid,
    input  logic [tag_width-1:0]                tag,
    input  logic [index_width-1:0]              index,
    input  logic [icache_pkg::offset_width-1:0] offset,
    input  logic                                uncached,
    output logic                                addr_ok,
    output logic                                data_ok,
    output icache_pkg::word_t                   rdata_l,
    output icache_pkg::word_t                   rdata_h,
    // memory read side
    output logic                                rd_req,
    output logic [2:0]                          rd_type,
    output icache_pkg::word_t                   rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  icache_pkg::word_t                   ret_data,
    // stores and fill buffer
    output logic                                preload,
    output logic [tag_width-1:0]                req_tag,
    output logic [index_width-1:0]              req_index,
    input  logic                                hit,
    input  icache_pkg::line_t                   hit_line,
    input  icache_pkg::line_t                   line_next,
    output logic                                fill,
    output logic                                fill_way,
    output logic                                fill_start
);

    localparam int word_bits = $bits(icache_pkg::word_t);

    typedef struct packed {
        logic [tag_width-1:0]                tag;
        logic [index_width-1:0]              index;
        logic [icache_pkg::offset_width-1:0] offset;
        logic                                uncached;
    } req_t;

    icache_pkg::cache_state_t state;
    req_t                     req;
    logic                     rd_sent;
    logic                     repl_way;
    logic                     hit_cached;
    logic                     refill_done;
    icache_pkg::line_t        resp_line;
    icache_pkg::word_sel_t    word_l;
    icache_pkg::word_sel_t    word_h;

    assign hit_cached  = (state == icache_pkg::lookup) && hit && !req.uncached;
    assign refill_done = (state == icache_pkg::refill) && ret_valid && ret_last;

    // accept from idle, or stream on behind a cached hit
    assign addr_ok = valid && ((state == icache_pkg::idle) || hit_cached);
    assign preload = addr_ok;
    assign data_ok = hit_cached || refill_done;

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req <= {tag, index, offset, uncached};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= icache_pkg::idle;
        end else begin
            case (state)
                icache_pkg::idle: begin
                    if (addr_ok) begin
                        state <= icache_pkg::lookup;
                    end
                end
                icache_pkg::lookup: begin
                    if (!hit_cached) begin
                        state <= icache_pkg::refill;
                    end else if (!valid) begin
                        state <= icache_pkg::idle;
                    end
                end
                icache_pkg::refill: begin
                    if (refill_done) begin
                        state <= icache_pkg::idle;
                    end
                end
                default: begin
                    state <= icache_pkg::idle;
                end
            endcase
        end
    end

    // one address per miss, dropped once memory takes it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_sent <= 1'b0;
        end else if (state != icache_pkg::refill) begin
            rd_sent <= 1'b0;
        end else if (rd_rdy) begin
            rd_sent <= 1'b1;
        end
    end

    assign rd_req     = (state == icache_pkg::refill) && !rd_sent;
    assign fill_start = rd_req && rd_rdy;
    assign rd_type    = req.uncached ? icache_pkg::rd_type_word : icache_pkg::rd_type_line;
    assign rd_addr    = req.uncached ? {req.tag, req.index, req.offset}
                                     : {req.tag, req.index, {icache_pkg::offset_width{1'b0}}};

    // round-robin victim, flips after every cached refill
    always_ff @(posedge clk) begin
        if (!resetn) begin
            repl_way <= 1'b0;
        end else if (fill) begin
            repl_way <= !repl_way;
        end
    end

    assign fill      = refill_done && !req.uncached;
    assign fill_way  = repl_way;
    assign req_tag   = req.tag;
    assign req_index = req.index;

    // refill answers straight from the fill buffer
    assign resp_line = (state == icache_pkg::refill) ? line_next : hit_line;
    assign word_l    = req.offset[icache_pkg::offset_width-1:2];
    assign word_h    = word_l + 1'b1;
    assign rdata_l   = req.uncached ? ret_data
                                    : resp_line[word_bits*word_l +: word_bits];
    assign rdata_h   = resp_line[word_bits*word_h +: word_bits];

    // an issued read keeps the controller in refill until memory answers
    assert property (@(posedge clk) disable iff (!resetn)
        rd_req |=> state == icache_pkg::refill);

    // word reads come back as a single beat
    assert property (@(posedge clk) disable iff (!resetn)
        (state == icache_pkg::refill) && req.uncached && ret_valid |-> ret_last);

endmodule

`default_nettype wire

//--- hdl/icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache #(
    parameter int index_width = 8,
    localparam int tag_width = icache_pkg::tag_width_of(index_width)
) (
    input  logic                                clk,
    input  logic                                resetn,
    // pipe side
    input  logic                                valid,
    input  logic [tag_width-1:0]                tag,
    input  logic [index_width-1:0]              index,
    input  logic [icache_pkg::offset_width-1:0] offset,
    input  logic                                uncached,
    output logic                                addr_ok,
    output logic                                data_ok,
    output icache_pkg::word_t                   rdata_l,
    output icache_pkg::word_t                   rdata_h,
    // memory read side
    output logic                                rd_req,
    output logic [2:0]                          rd_type,
    output icache_pkg::word_t                   rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  icache_pkg::word_t                   ret_data
);

    logic                   preload;
    logic [tag_width-1:0]   req_tag;
    logic [index_width-1:0] req_index;
    logic                   hit;
    logic                   hit_way;
    icache_pkg::line_t      hit_line;
    icache_pkg::line_t      line_next;
    logic                   fill;
    logic                   fill_way;
    logic                   fill_start;

    icache_ctrl #(.index_width(index_width)) u_ctrl (
        .clk, .resetn,
        .valid, .tag, .index, .offset, .uncached,
        .addr_ok, .data_ok, .rdata_l, .rdata_h,
        .rd_req, .rd_type, .rd_addr, .rd_rdy,
        .ret_valid, .ret_last, .ret_data,
        .preload, .req_tag, .req_index,
        .hit, .hit_line, .line_next,
        .fill, .fill_way, .fill_start
    );

    // the pipe index goes straight to both stores for the preload read
    icache_tag_store #(.index_width(index_width)) u_tag_store (
        .clk, .resetn,
        .preload, .preload_index(index),
        .lookup_tag(req_tag), .lookup_index(req_index),
        .fill, .fill_way,
        .hit, .hit_way
    );

    icache_data_store #(.index_width(index_width)) u_data_store (
        .clk,
        .preload, .preload_index(index),
        .hit_way,
        .fill, .fill_way, .fill_index(req_index), .fill_line(line_next),
        .hit_line
    );

    icache_line_fill u_line_fill (
        .clk, .resetn,
        .start(fill_start), .ret_valid, .ret_last, .ret_data,
        .line(), .line_next
    );

endmodule

`default_nettype wire

//--- tests/icache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

    localparam int index_width = 8;
    localparam int tag_width = icache_pkg::tag_width_of(index_width);
    localparam int n_requests = 200;
    localparam int n_random = n_requests - 24;
    localparam int timeout_cycles = n_requests * 40;
    localparam realtime skew = 0.5;
    localparam logic [2:0] type_word = 3'b010;
    localparam logic [2:0] type_line = 3'b100;
    localparam logic [31:0] mem_pattern = 32'h5a5a_5a5a;
    // small pools so lines get reused and evicted
    localparam logic [tag_width-1:0] tag_pool [4] = '{20'h00000, 20'h00001, 20'h3c5a1, 20'hfffff};
    localparam logic [index_width-1:0] index_pool [4] = '{8'h00, 8'h01, 8'h7f, 8'h80};

    typedef struct packed {
        logic [tag_width-1:0]   tag;
        logic [index_width-1:0] index;
        logic [3:0]             offset;
        logic                   uncached;
        logic                   hit;
        logic [31:0]            cycle;
    } pending_t;

    logic                   clk;
    logic                   resetn;
    logic                   valid;
    logic [tag_width-1:0]   tag;
    logic [index_width-1:0] index;
    logic [3:0]             offset;
    logic                   uncached;
    logic                   addr_ok;
    logic                   data_ok;
    icache_pkg::word_t      rdata_l;
    icache_pkg::word_t      rdata_h;
    logic                   rd_req;
    logic [2:0]             rd_type;
    icache_pkg::word_t      rd_addr;
    logic                   rd_rdy;
    logic                   ret_valid;
    logic                   ret_last;
    icache_pkg::word_t      ret_data;

    logic [15:0]            lfsr = 16'd46;
    logic [tag_width-1:0]   model_tag [2][1 << index_width];
    logic                   model_valid [2][1 << index_width];
    logic                   model_ptr;
    pending_t               pending [$];
    logic                   rd_req_q;
    int                     cycle = 0;
    int                     accepted = 0;
    int                     checks = 0;
    int                     mismatches = 0;
    int                     failures = 0;
    int                     miss_count = 0;

    icache #(.index_width(index_width)) DUT (
        .clk, .resetn,
        .valid, .tag, .index, .offset, .uncached,
        .addr_ok, .data_ok, .rdata_l, .rdata_h,
        .rd_req, .rd_type, .rd_addr, .rd_rdy,
        .ret_valid, .ret_last, .ret_data
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // feedback taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[6:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ mem_pattern;
    endfunction

    // two ways with a round-robin victim that flips on every cached fill
    function automatic logic model_access(input logic [tag_width-1:0] t,
                                          input logic [index_width-1:0] i, input logic unc);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (!unc && model_valid[w][i] && model_tag[w][i] == t) begin
                hit = 1'b1;
            end
        end
        if (!unc && !hit) begin
            model_tag[model_ptr][i]   = t;
            model_valid[model_ptr][i] = 1'b1;
            model_ptr                 = !model_ptr;
        end
        return hit;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(input string what);
        failures++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic record_accept();
        pending_t p;
        p.tag      = tag;
        p.index    = index;
        p.offset   = offset;
        p.uncached = uncached;
        p.hit      = model_access(tag, index, uncached);
        p.cycle    = cycle;
        pending.push_back(p);
        accepted++;
    endtask

    task automatic check_response();
        pending_t          p;
        logic [31:0]       addr;
        int                latency;
        if (pending.size() == 0) begin
            note_failure("data_ok with no request outstanding");
        end else begin
            p       = pending.pop_front();
            addr    = {p.tag, p.index, p.offset};
            latency = cycle - p.cycle;
            compare_value("rdata_l", rdata_l, mem_word(addr));
            if (!p.uncached && p.offset[3:2] != 2'd3) begin
                compare_value("rdata_h", rdata_h, mem_word(addr + 32'd4));
            end
            assert (p.hit ? latency == 1 : latency > 1) else begin
                note_failure($sformatf("%s answered %0d cycles after acceptance",
                                       p.hit ? "predicted hit" : "predicted miss", latency));
            end
        end
    endtask

    task automatic check_read();
        pending_t p;
        miss_count++;
        assert (pending.size() == 1) else begin
            note_failure($sformatf("memory read with %0d requests outstanding", pending.size()));
        end
        if (pending.size() != 0) begin
            p = pending[0];
            assert (!p.hit) else note_failure("predicted hit issued a memory read");
            if (p.uncached) begin
                compare_value("rd_type", rd_type, type_word);
                compare_value("rd_addr", rd_addr, {p.tag, p.index, p.offset});
            end else begin
                compare_value("rd_type", rd_type, type_line);
                compare_value("rd_addr", rd_addr, {p.tag, p.index, 4'h0});
            end
        end
    endtask

    // outputs are sampled at the falling edge half a cycle after the drive
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d requests accepted", cycle, accepted);
            $display("SIMULATION FAILED");
            $finish;
        end else if (resetn) begin
            if (data_ok) begin
                check_response();
            end
            if (rd_req && !rd_req_q) begin
                check_read();
            end
            if (addr_ok) begin
                record_accept();
            end
            rd_req_q = rd_req;
        end else begin
            rd_req_q = 1'b0;
        end
    end

    // memory responder drawing its random delays on the falling edge
    initial begin : memory
        icache_pkg::word_t base;
        int                beats;
        int                delay;
        int                gaps [4];
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                base  = rd_addr;
                beats = (rd_type == type_line) ? 4 : 1;
                delay = rand_bits(2);
                for (int b = 0; b < 4; b++) begin
                    gaps[b] = rand_bits(1);
                end
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #skew rd_rdy = 1'b1;
                @(posedge clk);
                #skew rd_rdy = 1'b0;
                for (int b = 0; b < beats; b++) begin
                    repeat (gaps[b]) begin
                        @(posedge clk);
                        #skew;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == beats - 1);
                    ret_data  = mem_word(base + 32'(4 * b));
                    @(posedge clk);
                    #skew;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    task automatic send_req(input logic [tag_width-1:0] t, input logic [index_width-1:0] i,
                            input logic [3:0] o, input logic u, input logic stream);
        int waits;
        waits    = 0;
        valid    = 1'b1;
        tag      = t;
        index    = i;
        offset   = o;
        uncached = u;
        @(negedge clk);
        while (!addr_ok) begin
            waits++;
            @(negedge clk);
        end
        assert (!stream || waits == 0) else begin
            note_failure($sformatf("hit stream stalled for %0d cycles", waits));
        end
        @(posedge clk);
        #skew valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (pending.size() != 0) begin
            @(posedge clk);
            #skew;
        end
    endtask

    task automatic fill_and_stream();
        logic [7:0] r;
        int         base_misses;
        for (int i = 0; i < 4; i++) begin
            send_req(tag_pool[0], index_pool[i], 4'h0, 1'b0, 1'b0);
        end
        wait_idle();
        base_misses = miss_count;
        for (int i = 0; i < 16; i++) begin
            r = rand_bits(2);
            send_req(tag_pool[0], index_pool[i % 4], {r[1:0], 2'b00}, 1'b0, 1'b1);
        end
        wait_idle();
        assert (miss_count == base_misses) else note_failure("hit stream issued memory reads");
    endtask

    // three tags on one set and then the first tag again
    task automatic evict_and_reuse();
        int base_misses;
        base_misses = miss_count;
        for (int k = 1; k <= 4; k++) begin
            send_req(tag_pool[k % 4 == 0 ? 1 : k], 8'h40, 4'h4, 1'b0, 1'b0);
        end
        wait_idle();
        assert (miss_count == base_misses + 4) else begin
            note_failure("first line of set 40 still hit after two later fills");
        end
    endtask

    task automatic random_requests();
        logic [7:0]             r;
        logic [tag_width-1:0]   t;
        logic [index_width-1:0] i;
        logic [3:0]             o;
        logic                   u;
        for (int n = 0; n < n_random; n++) begin
            r = rand_bits(2);
            t = tag_pool[r[1:0]];
            r = rand_bits(2);
            i = index_pool[r[1:0]];
            r = rand_bits(2);
            o = {r[1:0], 2'b00};
            r = rand_bits(3);
            u = (r[2:0] == 3'd0);
            send_req(t, i, o, u, 1'b0);
            r = rand_bits(2);
            if (r[1:0] == 2'd0) begin
                r = rand_bits(2);
                repeat (r[1:0]) begin
                    @(posedge clk);
                    #skew;
                end
            end
        end
    endtask

    initial begin : stimulus
        resetn    = 1'b0;
        valid     = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        uncached  = 1'b0;
        model_ptr = 1'b0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < (1 << index_width); s++) begin
                model_valid[w][s] = 1'b0;
            end
        end
        repeat (8) @(posedge clk);
        #skew resetn = 1'b1;
        @(negedge clk);
        assert (!addr_ok && !data_ok && !rd_req) else note_failure("outputs high after reset");
        @(posedge clk);
        #skew;
        fill_and_stream();
        evict_and_reuse();
        random_requests();
        wait_idle();
        repeat (4) @(posedge clk);
        $display("requests %0d, checks %0d, mismatches %0d, other errors %0d",
                 accepted, checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- icache.f
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_line_fill.sv
hdl/icache_ctrl.sv
hdl/icache.sv
tests/icache_tb.sv

//--- Makefile
# Verilator build and run of the icache testbench

SOURCES := $(shell cat icache.f)

.PHONY: run clean

run: obj_dir/Vicache_tb
	./obj_dir/Vicache_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

obj_dir/Vicache_tb: icache.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module icache_tb -f icache.f -o Vicache_tb

clean:
	rm -rf obj_dir sim.log
